/* src/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // address and block geometry
    localparam int ADDR_WIDTH = 16;
    localparam int BLOCK_BITS = 32;
    localparam int OFFSET_BITS = $clog2(BLOCK_BITS / 8);

    // default organisation of one bank
    localparam int DEFAULT_NUM_SET = 16;
    localparam int DEFAULT_NUM_WAY = 4;

    localparam int PORT_BITS = 1;

    // valid for the default geometry only
    localparam int INDEX_BITS = $clog2(DEFAULT_NUM_SET);
    localparam int TAG_BITS = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

    typedef logic [BLOCK_BITS-1:0] block_t;

    // cpu byte address split for the default geometry
    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [INDEX_BITS-1:0]  index;
        logic [OFFSET_BITS-1:0] offset;
    } cpu_addr_t;

    // access input and miss request
    typedef struct packed {
        logic                 valid;
        logic [PORT_BITS-1:0] port;
        cpu_addr_t            addr;
    } access_pkt_t;

    // return channel and fetched block from the next level
    typedef struct packed {
        logic [PORT_BITS-1:0] port;
        cpu_addr_t            addr;
        block_t               data;
    } return_pkt_t;

    // one access at a time, no pipeline
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        JUDGE,
        READ_HIT,
        MISS_REQ,
        WAIT_FILL,
        RETURN
    } ctrl_state_t;

endpackage

`default_nettype wire

/* src/data_store.sv */
`timescale 1ns/1ns
`default_nettype none

module data_store #(
    parameter int NUM_SET = 16,
    parameter int NUM_WAY = 4,
    localparam int SET_BITS = $clog2(NUM_SET),
    localparam int WAY_BITS = $clog2(NUM_WAY)
) (
    input  wire logic                clk_in,

    input  wire logic                rd_en,
    input  wire logic [SET_BITS-1:0] rd_set,
    input  wire logic [WAY_BITS-1:0] rd_way,
    output cache_pkg::block_t        rd_data,

    input  wire logic                wr_en,
    input  wire logic [SET_BITS-1:0] wr_set,
    input  wire logic [WAY_BITS-1:0] wr_way,
    input  wire cache_pkg::block_t   wr_data
);

    // one block per set and way
    cache_pkg::block_t mem [NUM_SET][NUM_WAY];

    always_ff @(posedge clk_in)
    begin
        if (wr_en)
        begin
            mem[wr_set][wr_way] <= wr_data;
        end
    end

    // registered read, data held until the next rd_en
    always_ff @(posedge clk_in)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_set][rd_way];
        end
    end

endmodule

`default_nettype wire

/* src/tag_store.sv */
`timescale 1ns/1ns
`default_nettype none

module tag_store #(
    parameter int NUM_SET = 16,
    parameter int NUM_WAY = 4,
    localparam int SET_BITS = $clog2(NUM_SET),
    localparam int WAY_BITS = $clog2(NUM_WAY),
    localparam int TAG_W = cache_pkg::ADDR_WIDTH - SET_BITS - cache_pkg::OFFSET_BITS
) (
    input  wire logic                clk_in,
    input  wire logic                reset_in,
    input  wire logic                lookup_en,
    input  wire logic [SET_BITS-1:0] lookup_set,
    input  wire logic [TAG_W-1:0]    lookup_tag,
    output logic                     hit,
    output logic [WAY_BITS-1:0]      hit_way,
    output logic [WAY_BITS-1:0]      victim_way,
    input  wire logic                touch_en,
    input  wire logic [SET_BITS-1:0] touch_set,
    input  wire logic [WAY_BITS-1:0] touch_way,
    input  wire logic                fill_en,
    input  wire logic [SET_BITS-1:0] fill_set,
    input  wire logic [WAY_BITS-1:0] fill_way,
    input  wire logic [TAG_W-1:0]    fill_tag
);

    logic [NUM_WAY-1:0] valid_q   [NUM_SET];
    logic [NUM_WAY-1:0] history_q [NUM_SET];
    logic [TAG_W-1:0]   tag_q     [NUM_SET][NUM_WAY];
    logic [SET_BITS-1:0] set_q;

    // mark one way; once every way would be marked, only that way stays
    function automatic logic [NUM_WAY-1:0] mark_way(input logic [NUM_WAY-1:0] old_hist,
                                                    input logic [WAY_BITS-1:0] way);
        logic [NUM_WAY-1:0] one_hot;
        one_hot = '0;
        one_hot[way] = 1'b1;
        if (&(old_hist | one_hot))
        begin
            return one_hot;
        end
        return old_hist | one_hot;
    endfunction

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            set_q <= '0;
            for (int s = 0; s < NUM_SET; s++)
            begin
                valid_q[s] <= '0;
                history_q[s] <= '0;
            end
        end
        else
        begin
            if (lookup_en)
            begin
                set_q <= lookup_set;
            end
            if (fill_en)
            begin
                valid_q[fill_set][fill_way] <= 1'b1;
                history_q[fill_set] <= mark_way(history_q[fill_set], fill_way);
            end
            else if (touch_en)
            begin
                history_q[touch_set] <= mark_way(history_q[touch_set], touch_way);
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (fill_en)
        begin
            tag_q[fill_set][fill_way] <= fill_tag;
        end
    end

    // hit and victim for the registered set, lowest way first
    always_comb
    begin
        logic found_inv;
        logic found_old;
        hit = 1'b0;
        hit_way = '0;
        victim_way = '0;
        found_inv = 1'b0;
        found_old = 1'b0;
        for (int w = NUM_WAY - 1; w >= 0; w--)
        begin
            if (valid_q[set_q][w] && tag_q[set_q][w] == lookup_tag)
            begin
                hit = 1'b1;
                hit_way = WAY_BITS'(w);
            end
        end
        for (int w = 0; w < NUM_WAY; w++)
        begin
            if (!found_inv && !valid_q[set_q][w])
            begin
                found_inv = 1'b1;
                victim_way = WAY_BITS'(w);
            end
        end
        for (int w = 0; w < NUM_WAY; w++)
        begin
            if (!found_inv && !found_old && !history_q[set_q][w])
            begin
                found_old = 1'b1;
                victim_way = WAY_BITS'(w);
            end
        end
    end

endmodule

`default_nettype wire

/* src/bank_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module bank_ctrl #(
    parameter int NUM_SET = 16,
    parameter int NUM_WAY = 4,
    localparam int SET_BITS = $clog2(NUM_SET),
    localparam int WAY_BITS = $clog2(NUM_WAY),
    localparam int TAG_W = cache_pkg::ADDR_WIDTH - SET_BITS - cache_pkg::OFFSET_BITS
) (
    input  wire logic                   clk_in,
    input  wire logic                   reset_in,

    input  wire cache_pkg::access_pkt_t access_packet,
    output logic                        access_ack,
    output cache_pkg::access_pkt_t      miss_request,
    output logic                        miss_valid,
    input  wire logic                   miss_ack,
    input  wire cache_pkg::return_pkt_t fetched_request,
    input  wire logic                   fetched_valid,
    output logic                        fetched_ack,
    output cache_pkg::return_pkt_t      return_request,
    output logic                        return_valid,
    input  wire logic                   return_ack,

    output logic                        lookup_en,
    output logic [SET_BITS-1:0]         lookup_set,
    output logic [TAG_W-1:0]            lookup_tag,
    input  wire logic                   hit,
    input  wire logic [WAY_BITS-1:0]    hit_way,
    input  wire logic [WAY_BITS-1:0]    victim_way,
    output logic                        touch_en,
    output logic [SET_BITS-1:0]         touch_set,
    output logic [WAY_BITS-1:0]         touch_way,
    output logic                        fill_en,
    output logic [SET_BITS-1:0]         fill_set,
    output logic [WAY_BITS-1:0]         fill_way,
    output logic [TAG_W-1:0]            fill_tag,

    output logic                        rd_en,
    output logic [SET_BITS-1:0]         rd_set,
    output logic [WAY_BITS-1:0]         rd_way,
    input  wire cache_pkg::block_t      rd_data,
    output logic                        wr_en,
    output logic [SET_BITS-1:0]         wr_set,
    output logic [WAY_BITS-1:0]         wr_way,
    output cache_pkg::block_t           wr_data
);

    cache_pkg::ctrl_state_t state;
    logic                   bank_lock;
    logic                   issue_grant;
    logic                   take_fill;

    // accepted access, held until access_ack
    cache_pkg::access_pkt_t             req;
    logic [cache_pkg::ADDR_WIDTH-1:0]   req_addr_bits;
    logic [SET_BITS-1:0]                req_set;
    logic [TAG_W-1:0]                   req_tag;
    logic [WAY_BITS-1:0]                victim_q;

    // lock stays set through the ack cycle so a held valid is not taken twice
    assign issue_grant = (state == cache_pkg::IDLE) && access_packet.valid && !bank_lock;
    assign take_fill = (state == cache_pkg::WAIT_FILL) && fetched_valid;

    assign req_addr_bits = req.addr;
    assign req_set = req_addr_bits[cache_pkg::OFFSET_BITS +: SET_BITS];
    assign req_tag = req_addr_bits[cache_pkg::ADDR_WIDTH-1 -: TAG_W];

    // tag lookup in LOOKUP, answer seen in JUDGE
    assign lookup_en = (state == cache_pkg::LOOKUP);
    assign lookup_set = req_set;
    assign lookup_tag = req_tag;

    // hit: read the block and mark the way in the same cycle
    assign rd_en = (state == cache_pkg::JUDGE) && hit;
    assign rd_set = req_set;
    assign rd_way = hit_way;
    assign touch_en = rd_en;
    assign touch_set = req_set;
    assign touch_way = hit_way;

    // miss: block, tag and valid go into the victim chosen at JUDGE
    assign wr_en = take_fill;
    assign wr_set = req_set;
    assign wr_way = victim_q;
    assign wr_data = fetched_request.data;
    assign fill_en = take_fill;
    assign fill_set = req_set;
    assign fill_way = victim_q;
    assign fill_tag = req_tag;

    assign miss_request = '{valid: miss_valid, port: req.port, addr: req.addr};

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state <= cache_pkg::IDLE;
            bank_lock <= 1'b0;
            access_ack <= 1'b0;
            miss_valid <= 1'b0;
            fetched_ack <= 1'b0;
            return_valid <= 1'b0;
        end
        else
        begin
            access_ack <= 1'b0;
            fetched_ack <= 1'b0;
            if (access_ack)
            begin
                bank_lock <= 1'b0;
            end
            case (state)
                cache_pkg::IDLE:
                begin
                    if (issue_grant)
                    begin
                        bank_lock <= 1'b1;
                        state <= cache_pkg::LOOKUP;
                    end
                end
                cache_pkg::LOOKUP:
                begin
                    state <= cache_pkg::JUDGE;
                end
                cache_pkg::JUDGE:
                begin
                    if (hit)
                    begin
                        state <= cache_pkg::READ_HIT;
                    end
                    else
                    begin
                        miss_valid <= 1'b1;
                        state <= cache_pkg::MISS_REQ;
                    end
                end
                cache_pkg::READ_HIT:
                begin
                    return_valid <= 1'b1;
                    state <= cache_pkg::RETURN;
                end
                cache_pkg::MISS_REQ:
                begin
                    if (miss_ack)
                    begin
                        miss_valid <= 1'b0;
                        state <= cache_pkg::WAIT_FILL;
                    end
                end
                cache_pkg::WAIT_FILL:
                begin
                    if (take_fill)
                    begin
                        fetched_ack <= 1'b1;
                        return_valid <= 1'b1;
                        state <= cache_pkg::RETURN;
                    end
                end
                cache_pkg::RETURN:
                begin
                    if (return_ack)
                    begin
                        return_valid <= 1'b0;
                        access_ack <= 1'b1;
                        state <= cache_pkg::IDLE;
                    end
                end
                default:
                begin
                    state <= cache_pkg::IDLE;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk_in)
    begin
        if (issue_grant)
        begin
            req <= access_packet;
        end
        if (state == cache_pkg::JUDGE)
        begin
            victim_q <= victim_way;
        end
        if (state == cache_pkg::READ_HIT)
        begin
            return_request <= '{port: req.port, addr: req.addr, data: rd_data};
        end
        else if (take_fill)
        begin
            return_request <= '{port: req.port, addr: req.addr, data: fetched_request.data};
        end
    end

endmodule

`default_nettype wire

/* src/cache_bank_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_bank_top #(
    parameter int NUM_SET = cache_pkg::DEFAULT_NUM_SET,
    parameter int NUM_WAY = cache_pkg::DEFAULT_NUM_WAY
) (
    input  wire logic                   clk_in,
    input  wire logic                   reset_in,

    input  wire cache_pkg::access_pkt_t access_packet,
    output logic                        access_ack,

    output cache_pkg::access_pkt_t      miss_request,
    output logic                        miss_valid,
    input  wire logic                   miss_ack,

    input  wire cache_pkg::return_pkt_t fetched_request,
    input  wire logic                   fetched_valid,
    output logic                        fetched_ack,

    output cache_pkg::return_pkt_t      return_request,
    output logic                        return_valid,
    input  wire logic                   return_ack
);

    localparam int SET_BITS = $clog2(NUM_SET);
    localparam int WAY_BITS = $clog2(NUM_WAY);
    localparam int TAG_W = cache_pkg::ADDR_WIDTH - SET_BITS - cache_pkg::OFFSET_BITS;

    // tag store lookup and update
    logic                lookup_en;
    logic [SET_BITS-1:0] lookup_set;
    logic [TAG_W-1:0]    lookup_tag;
    logic                hit;
    logic [WAY_BITS-1:0] hit_way;
    logic [WAY_BITS-1:0] victim_way;
    logic                touch_en;
    logic [SET_BITS-1:0] touch_set;
    logic [WAY_BITS-1:0] touch_way;
    logic                fill_en;
    logic [SET_BITS-1:0] fill_set;
    logic [WAY_BITS-1:0] fill_way;
    logic [TAG_W-1:0]    fill_tag;

    // data store ports
    logic                rd_en;
    logic [SET_BITS-1:0] rd_set;
    logic [WAY_BITS-1:0] rd_way;
    cache_pkg::block_t   rd_data;
    logic                wr_en;
    logic [SET_BITS-1:0] wr_set;
    logic [WAY_BITS-1:0] wr_way;
    cache_pkg::block_t   wr_data;

    bank_ctrl #(
        .NUM_SET (NUM_SET),
        .NUM_WAY (NUM_WAY)
    ) ctrl_i (
        .clk_in          (clk_in),
        .reset_in        (reset_in),
        .access_packet   (access_packet),
        .access_ack      (access_ack),
        .miss_request    (miss_request),
        .miss_valid      (miss_valid),
        .miss_ack        (miss_ack),
        .fetched_request (fetched_request),
        .fetched_valid   (fetched_valid),
        .fetched_ack     (fetched_ack),
        .return_request  (return_request),
        .return_valid    (return_valid),
        .return_ack      (return_ack),
        .lookup_en       (lookup_en),
        .lookup_set      (lookup_set),
        .lookup_tag      (lookup_tag),
        .hit             (hit),
        .hit_way         (hit_way),
        .victim_way      (victim_way),
        .touch_en        (touch_en),
        .touch_set       (touch_set),
        .touch_way       (touch_way),
        .fill_en         (fill_en),
        .fill_set        (fill_set),
        .fill_way        (fill_way),
        .fill_tag        (fill_tag),
        .rd_en           (rd_en),
        .rd_set          (rd_set),
        .rd_way          (rd_way),
        .rd_data         (rd_data),
        .wr_en           (wr_en),
        .wr_set          (wr_set),
        .wr_way          (wr_way),
        .wr_data         (wr_data)
    );

    tag_store #(
        .NUM_SET (NUM_SET),
        .NUM_WAY (NUM_WAY)
    ) tags_i (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .lookup_en  (lookup_en),
        .lookup_set (lookup_set),
        .lookup_tag (lookup_tag),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .touch_en   (touch_en),
        .touch_set  (touch_set),
        .touch_way  (touch_way),
        .fill_en    (fill_en),
        .fill_set   (fill_set),
        .fill_way   (fill_way),
        .fill_tag   (fill_tag)
    );

    data_store #(
        .NUM_SET (NUM_SET),
        .NUM_WAY (NUM_WAY)
    ) data_i (
        .clk_in  (clk_in),
        .rd_en   (rd_en),
        .rd_set  (rd_set),
        .rd_way  (rd_way),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_set  (wr_set),
        .wr_way  (wr_way),
        .wr_data (wr_data)
    );

endmodule

`default_nettype wire

/* dv/cache_bank_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_bank_properties (
    input wire logic                   clk_in,
    input wire logic                   reset_in,
    input wire logic                   access_ack,
    input wire cache_pkg::access_pkt_t miss_request,
    input wire logic                   miss_valid,
    input wire logic                   miss_ack,
    input wire cache_pkg::return_pkt_t return_request,
    input wire logic                   return_valid,
    input wire logic                   return_ack
);

    // return channel held until return_ack
    return_held: assert property (@(posedge clk_in) disable iff (reset_in)
        return_valid && !return_ack |=> return_valid && $stable(return_request))
        else $error("return channel changed before return_ack");

    miss_held: assert property (@(posedge clk_in) disable iff (reset_in)
        miss_valid && !miss_ack |=> miss_valid && $stable(miss_request))
        else $error("miss channel changed before miss_ack");

    // one cycle per access
    ack_pulse: assert property (@(posedge clk_in) disable iff (reset_in)
        access_ack |=> !access_ack)
        else $error("access_ack high for two cycles");

endmodule

bind cache_bank_top cache_bank_properties props_i (
    .clk_in         (clk_in),
    .reset_in       (reset_in),
    .access_ack     (access_ack),
    .miss_request   (miss_request),
    .miss_valid     (miss_valid),
    .miss_ack       (miss_ack),
    .return_request (return_request),
    .return_valid   (return_valid),
    .return_ack     (return_ack)
);

`default_nettype wire

/* dv/tb_cache_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cache_bank;

    localparam int NUM_SET = cache_pkg::DEFAULT_NUM_SET;
    localparam int NUM_WAY = cache_pkg::DEFAULT_NUM_WAY;
    localparam int HIT_LATENCY = 5;

    logic                   clk_in;
    logic                   reset_in;
    cache_pkg::access_pkt_t access_packet;
    logic                   access_ack;
    cache_pkg::access_pkt_t miss_request;
    logic                   miss_valid;
    logic                   miss_ack;
    cache_pkg::return_pkt_t fetched_request;
    logic                   fetched_valid;
    logic                   fetched_ack;
    cache_pkg::return_pkt_t return_request;
    logic                   return_valid;
    logic                   return_ack;

    // expected tag state and contents per set and way
    logic                           ref_valid [NUM_SET][NUM_WAY];
    logic                           ref_hist  [NUM_SET][NUM_WAY];
    logic [cache_pkg::TAG_BITS-1:0] ref_tag   [NUM_SET][NUM_WAY];
    cache_pkg::block_t              ref_data  [NUM_SET][NUM_WAY];

    int errors;
    int timeouts;
    int cases_run;
    int seed;

    cache_bank_top #(
        .NUM_SET (NUM_SET),
        .NUM_WAY (NUM_WAY)
    ) dut_i (
        .clk_in          (clk_in),
        .reset_in        (reset_in),
        .access_packet   (access_packet),
        .access_ack      (access_ack),
        .miss_request    (miss_request),
        .miss_valid      (miss_valid),
        .miss_ack        (miss_ack),
        .fetched_request (fetched_request),
        .fetched_valid   (fetched_valid),
        .fetched_ack     (fetched_ack),
        .return_request  (return_request),
        .return_valid    (return_valid),
        .return_ack      (return_ack)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    // set the history bit and keep only the newest once the set is full
    function automatic void mark_used(input int set, input int way);
        bit full;
        ref_hist[set][way] = 1'b1;
        full = 1'b1;
        for (int w = 0; w < NUM_WAY; w++)
        begin
            if (!ref_hist[set][w])
            begin
                full = 1'b0;
            end
        end
        if (full)
        begin
            for (int w = 0; w < NUM_WAY; w++)
            begin
                ref_hist[set][w] = (w == way);
            end
        end
    endfunction

    // predicted hit and returned block with the model updated as the bank would be
    function automatic void predict(input logic [cache_pkg::ADDR_WIDTH-1:0] addr,
                                    input cache_pkg::block_t fill,
                                    output logic exp_hit,
                                    output cache_pkg::block_t exp_data);
        int set;
        int way;
        logic [cache_pkg::TAG_BITS-1:0] tag;
        set = int'(addr[cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS]);
        tag = addr[cache_pkg::ADDR_WIDTH-1 -: cache_pkg::TAG_BITS];
        way = -1;
        for (int w = 0; w < NUM_WAY; w++)
        begin
            if (way < 0 && ref_valid[set][w] && ref_tag[set][w] == tag)
            begin
                way = w;
            end
        end
        exp_hit = (way >= 0);
        if (exp_hit)
        begin
            exp_data = ref_data[set][way];
        end
        else
        begin
            // lowest invalid way first, then lowest with history clear
            for (int w = 0; w < NUM_WAY; w++)
            begin
                if (way < 0 && !ref_valid[set][w])
                begin
                    way = w;
                end
            end
            for (int w = 0; w < NUM_WAY; w++)
            begin
                if (way < 0 && !ref_hist[set][w])
                begin
                    way = w;
                end
            end
            ref_valid[set][way] = 1'b1;
            ref_tag[set][way] = tag;
            ref_data[set][way] = fill;
            exp_data = fill;
        end
        mark_used(set, way);
    endfunction

    // one access as requester and next level until access_ack
    task automatic run_access(input logic [cache_pkg::ADDR_WIDTH-1:0] addr,
                              input logic port,
                              input cache_pkg::block_t fill,
                              input int miss_delay,
                              input int ret_delay,
                              output bit timed_out);
        logic                   exp_hit;
        cache_pkg::block_t      exp_data;
        cache_pkg::access_pkt_t exp_miss;
        cache_pkg::return_pkt_t exp_ret;
        bit                     saw_miss;
        bit                     miss_done;
        bit                     fetch_done;
        bit                     ret_done;
        bit                     done;
        int                     miss_wait;
        int                     ret_wait;
        int                     cycles;
        int                     limit;
        predict(addr, fill, exp_hit, exp_data);
        exp_miss.valid = 1'b1;
        exp_miss.port = port;
        exp_miss.addr = addr;
        exp_ret.port = port;
        exp_ret.addr = addr;
        exp_ret.data = exp_data;
        saw_miss = 1'b0;
        miss_done = 1'b0;
        fetch_done = 1'b0;
        ret_done = 1'b0;
        done = 1'b0;
        timed_out = 1'b0;
        miss_wait = 0;
        ret_wait = 0;
        cycles = 0;
        limit = 40 + miss_delay + ret_delay;

        access_packet.valid = 1'b1;
        access_packet.port = port;
        access_packet.addr = addr;
        fetched_request.port = port;
        fetched_request.addr = addr;
        fetched_request.data = fill;
        miss_ack = 1'b0;
        return_ack = (ret_delay == 0);

        while (!done && !timed_out)
        begin
            @(negedge clk_in);
            cycles++;
            if (miss_valid)
            begin
                saw_miss = 1'b1;
                if (miss_request !== exp_miss)
                begin
                    $display("Mismatch miss_request: got %h expected %h", miss_request, exp_miss);
                    errors++;
                end
                miss_ack = (miss_wait >= miss_delay);
                miss_done = miss_done | miss_ack;
                miss_wait++;
            end
            else
            begin
                miss_ack = 1'b0;
            end
            if (fetched_ack)
            begin
                fetched_valid = 1'b0;
                fetch_done = 1'b1;
            end
            else if (miss_done && !miss_valid && !fetch_done)
            begin
                fetched_valid = 1'b1;
            end
            if (return_valid)
            begin
                if (return_request !== exp_ret)
                begin
                    $display("Mismatch return_request: got %h expected %h",
                             return_request, exp_ret);
                    errors++;
                end
                return_ack = (ret_wait >= ret_delay);
                ret_done = ret_done | return_ack;
                ret_wait++;
            end
            else
            begin
                return_ack = (ret_delay == 0);
            end
            if (access_ack)
            begin
                done = 1'b1;
                if (!ret_done)
                begin
                    $display("access_ack for address %h came before the return handshake", addr);
                    errors++;
                end
                if (exp_hit && saw_miss)
                begin
                    $display("address %h should hit but raised a miss request", addr);
                    errors++;
                end
                if (!exp_hit && !fetch_done)
                begin
                    $display("address %h should miss but no block was fetched", addr);
                    errors++;
                end
                if (exp_hit && ret_delay == 0 && cycles != HIT_LATENCY)
                begin
                    $display("Mismatch hit latency: got %h expected %h", cycles, HIT_LATENCY);
                    errors++;
                end
            end
            else if (cycles >= limit)
            begin
                $display("timeout waiting for access_ack for address %h", addr);
                timeouts++;
                timed_out = 1'b1;
            end
        end
        access_packet.valid = 1'b0;
        miss_ack = 1'b0;
        fetched_valid = 1'b0;
        return_ack = 1'b0;
    endtask

    initial
    begin
        int                fd;
        int                n;
        int                gap;
        bit                abort;
        logic [31:0]       f_addr;
        logic [31:0]       f_port;
        logic [31:0]       f_fill;
        int                f_miss_delay;
        int                f_ret_delay;
        errors = 0;
        timeouts = 0;
        cases_run = 0;
        seed = 42;
        abort = 1'b0;
        reset_in = 1'b1;
        access_packet = '0;
        miss_ack = 1'b0;
        fetched_request = '0;
        fetched_valid = 1'b0;
        return_ack = 1'b0;
        for (int s = 0; s < NUM_SET; s++)
        begin
            for (int w = 0; w < NUM_WAY; w++)
            begin
                ref_valid[s][w] = 1'b0;
                ref_hist[s][w] = 1'b0;
            end
        end

        repeat (3) @(negedge clk_in);
        reset_in = 1'b0;
        @(negedge clk_in);
        if ({access_ack, miss_valid, return_valid, fetched_ack} !== 4'h0)
        begin
            $display(
                "Mismatch {access_ack, miss_valid, return_valid, fetched_ack}: got %h expected 0",
                {access_ack, miss_valid, return_valid, fetched_ack});
            errors++;
        end

        // case file columns are addr, port and fill block in hex, then the two ack delays
        fd = $fopen("dv/access_cases.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open case file dv/access_cases.txt");
            errors++;
        end
        else
        begin
            while (!abort)
            begin
                n = $fscanf(fd, "%h %h %h %d %d\n", f_addr, f_port, f_fill,
                            f_miss_delay, f_ret_delay);
                if (n == 5)
                begin
                    run_access(f_addr[cache_pkg::ADDR_WIDTH-1:0], f_port[0], f_fill,
                               f_miss_delay, f_ret_delay, abort);
                    cases_run++;
                    // valid stays low for at least one edge after the ack cycle
                    gap = 1 + $unsigned($random(seed)) % 4;
                    repeat (gap) @(negedge clk_in);
                end
                else
                begin
                    abort = 1'b1;
                end
            end
            $fclose(fd);
        end
        if (cases_run == 0)
        begin
            $display("no access cases were read from the case file");
            errors++;
        end

        $display("cases run: %0d, errors: %0d, timeouts: %0d", cases_run, errors, timeouts);
        if (errors == 0 && timeouts == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/access_cases.txt */
0044 0 a1b2c3d4 0 0
0044 1 00000000 0 0
0046 0 00000000 0 0
0084 1 0bad0084 0 0
00c4 0 0bad00c4 0 0
0104 1 0bad0104 0 0
0144 0 0bad0144 0 0
0104 1 00000000 0 0
00c4 0 00000000 0 0
0044 1 5eed0044 0 0
0144 0 00000000 0 0
0048 1 12340048 3 4
0088 0 12340088 1 2
00c8 1 123400c8 5 0
0108 0 12340108 0 3
0048 0 00000000 0 2
0088 1 00000000 0 0
00c8 0 00000000 0 0
0108 1 00000000 0 0
0148 0 ffff0148 2 1
0048 1 77770048 0 0

/* sources.f */
src/cache_pkg.sv
src/data_store.sv
src/tag_store.sv
src/bank_ctrl.sv
src/cache_bank_top.sv
dv/cache_bank_properties.sv
dv/tb_cache_bank.sv

/* run.sh */
#!/bin/sh
# build and run the cache bank testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns -f sources.f \
    --top-module tb_cache_bank -o tb_cache_bank

out=$(./obj_dir/tb_cache_bank 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "all tests passed"
then
    exit 0
fi
exit 1
